//--- rtl/uart_pkg.sv
// Register map, FSM state encodings and AXI response codes shared by the UART
// Offsets are byte addresses on a 4-bit AXI4-Lite address bus
package uart_pkg;

  // Register byte offsets
  typedef enum logic [3:0] {
    REG_TXDATA = 4'h0,
    REG_RXDATA = 4'h4,
    REG_STATUS = 4'h8
  } reg_addr_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // Status word bit positions
  localparam int STAT_TX_FULL   = 0;
  localparam int STAT_TX_IDLE   = 1;
  localparam int STAT_RX_VALID  = 2;
  localparam int STAT_OVERRUN   = 3;
  localparam int STAT_FRAME_ERR = 4;

endpackage

//--- rtl/uart_fifo.sv
// Show-ahead byte FIFO, FIFO_DEPTH must be a power of two and at least 2
// Push while full and pop while empty are silently ignored
`timescale 1ns/1ps

module uart_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  logic [7:0] wdata_i,
  input  logic       pop_i,
  output logic [7:0] rdata_o,
  output logic       full_o,
  output logic       empty_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [7:0]  mem [FIFO_DEPTH];
  // Extra MSB tells a full buffer from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head entry is visible without a pop
  assign rdata_o = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= wdata_i;
    end
  end

endmodule

//--- rtl/uart_tx.sv
// 8N1 serializer, one bit lasts CLKS_PER_BIT cycles (even, at least 4)
// Pops its FIFO while idle, the start bit follows on the next cycle
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fifo_empty_i,
  input  logic [7:0] fifo_data_i,
  output logic       fifo_pop_o,
  output logic       busy_o,
  output logic       tx_o
);

  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  tx_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;

  assign fifo_pop_o = (state == TX_IDLE) && !fifo_empty_i;
  assign busy_o     = (state != TX_IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_o    <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          tx_o <= 1'b1;
          if (!fifo_empty_i) begin
            state <= TX_START;
            cnt   <= '0;
            tx_o  <= 1'b0;
          end
        end
        TX_START: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= TX_DATA;
            tx_o    <= shreg[0];
          end
        end
        TX_DATA: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= TX_STOP;
              tx_o  <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_o    <= shreg[1];
            end
          end
        end
        TX_STOP: begin
          cnt <= cnt + 1'b1;
          // Back to idle, a new byte can pop on the following cycle
          if (cnt == CNT_LAST) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Byte shift register, LSB goes out first
  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      shreg <= fifo_data_i;
    end else if (state == TX_DATA && cnt == CNT_LAST) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

endmodule

//--- rtl/uart_rx.sv
// 8N1 deserializer with a two-flop input synchronizer, CLKS_PER_BIT even, >= 4
// A new frame starts only on a falling edge, so a low line after a bad stop bit is ignored
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rx_i,
  output logic [7:0] byte_o,
  output logic       byte_valid_o,
  output logic       frame_err_o
);

  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

  rx_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;

  assign byte_o = shreg;

  // Idle line level is high, also straight out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state        <= RX_IDLE;
      cnt          <= '0;
      bit_idx      <= '0;
      byte_valid_o <= 1'b0;
      frame_err_o  <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      frame_err_o  <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rx_prev && !rx_sync) begin
            state <= RX_START;
            cnt   <= '0;
          end
        end
        RX_START: begin
          cnt <= cnt + 1'b1;
          // Half a bit in, the line must still be low
          if (cnt == CNT_HALF) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            state        <= RX_IDLE;
            byte_valid_o <= rx_sync;
            frame_err_o  <= !rx_sync;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Mid-bit samples enter at the top, first bit ends up in bit 0
  always_ff @(posedge clk_i) begin
    if (state == RX_DATA && cnt == CNT_LAST) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
  end

endmodule

//--- rtl/uart_axil_regs.sv
// AXI4-Lite slave for the UART data and status registers
// One outstanding write and one outstanding read, only byte lane 0 is used
`timescale 1ns/1ps

module uart_axil_regs (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [3:0]  awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [3:0]  araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  output logic        tx_push_o,
  output logic [7:0]  tx_wdata_o,
  input  logic        tx_full_i,
  input  logic        tx_empty_i,
  input  logic        tx_busy_i,
  output logic        rx_pop_o,
  input  logic [7:0]  rx_rdata_i,
  input  logic        rx_empty_i,
  input  logic        rx_full_i,
  input  logic        rx_byte_valid_i,
  input  logic        rx_frame_err_i
);

  import uart_pkg::*;

  logic        wr_accept;
  logic        rd_accept;
  logic        wr_lane0;
  logic        stat_clr;
  logic        overrun_q;
  logic        frame_err_q;
  logic [31:0] status_word;

  // Address and data must arrive together, and the previous response must be taken
  assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign rd_accept = arvalid_i && !rvalid_o;
  assign arready_o = rd_accept;
  assign wr_lane0  = wstrb_i[0];

  assign tx_push_o  = wr_accept && (awaddr_i == REG_TXDATA) && wr_lane0 && !tx_full_i;
  assign tx_wdata_o = wdata_i[7:0];
  assign rx_pop_o   = rd_accept && (araddr_i == REG_RXDATA) && !rx_empty_i;
  assign stat_clr   = wr_accept && (awaddr_i == REG_STATUS) && wr_lane0;

  always_comb begin
    status_word                 = '0;
    status_word[STAT_TX_FULL]   = tx_full_i;
    status_word[STAT_TX_IDLE]   = !tx_busy_i && tx_empty_i;
    status_word[STAT_RX_VALID]  = !rx_empty_i;
    status_word[STAT_OVERRUN]   = overrun_q;
    status_word[STAT_FRAME_ERR] = frame_err_q;
  end

  // Write response channel
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bvalid_o <= 1'b0;
      bresp_o  <= RESP_OKAY;
    end else if (wr_accept) begin
      bvalid_o <= 1'b1;
      case (awaddr_i)
        REG_TXDATA: bresp_o <= (wr_lane0 && tx_full_i) ? RESP_SLVERR : RESP_OKAY;
        REG_STATUS: bresp_o <= RESP_OKAY;
        default:    bresp_o <= RESP_SLVERR;
      endcase
    end else if (bready_i) begin
      bvalid_o <= 1'b0;
    end
  end

  // Read data channel, handshake state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else if (rd_accept) begin
      rvalid_o <= 1'b1;
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  // Read payload, held until the next accepted read
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      case (araddr_i)
        REG_RXDATA: begin
          rdata_o <= rx_empty_i ? 32'h0 : {24'h0, rx_rdata_i};
          rresp_o <= rx_empty_i ? RESP_SLVERR : RESP_OKAY;
        end
        REG_STATUS: begin
          rdata_o <= status_word;
          rresp_o <= RESP_OKAY;
        end
        default: begin
          rdata_o <= 32'h0;
          rresp_o <= RESP_SLVERR;
        end
      endcase
    end
  end

  // Sticky error flags, a new event wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      if (rx_byte_valid_i && rx_full_i) begin
        overrun_q <= 1'b1;
      end else if (stat_clr && wdata_i[STAT_OVERRUN]) begin
        overrun_q <= 1'b0;
      end
      if (rx_frame_err_i) begin
        frame_err_q <= 1'b1;
      end else if (stat_clr && wdata_i[STAT_FRAME_ERR]) begin
        frame_err_q <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/uart_top.sv
// Memory-mapped 8N1 UART with an AXI4-Lite slave port
// Bit time is fixed by CLKS_PER_BIT, FIFO_DEPTH must be a power of two
`timescale 1ns/1ps

module uart_top #(
  parameter int CLKS_PER_BIT = 8,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [3:0]  awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [3:0]  araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic        rx_i,
  output logic        tx_o
);

  logic       tx_push;
  logic [7:0] tx_wdata;
  logic       tx_pop;
  logic [7:0] tx_head;
  logic       tx_full;
  logic       tx_empty;
  logic       tx_busy;
  logic       rx_pop;
  logic [7:0] rx_head;
  logic       rx_full;
  logic       rx_empty;
  logic [7:0] rx_byte;
  logic       rx_byte_valid;
  logic       rx_frame_err;

  uart_axil_regs u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .awaddr_i        (awaddr_i),
    .awvalid_i       (awvalid_i),
    .awready_o       (awready_o),
    .wdata_i         (wdata_i),
    .wstrb_i         (wstrb_i),
    .wvalid_i        (wvalid_i),
    .wready_o        (wready_o),
    .bresp_o         (bresp_o),
    .bvalid_o        (bvalid_o),
    .bready_i        (bready_i),
    .araddr_i        (araddr_i),
    .arvalid_i       (arvalid_i),
    .arready_o       (arready_o),
    .rdata_o         (rdata_o),
    .rresp_o         (rresp_o),
    .rvalid_o        (rvalid_o),
    .rready_i        (rready_i),
    .tx_push_o       (tx_push),
    .tx_wdata_o      (tx_wdata),
    .tx_full_i       (tx_full),
    .tx_empty_i      (tx_empty),
    .tx_busy_i       (tx_busy),
    .rx_pop_o        (rx_pop),
    .rx_rdata_i      (rx_head),
    .rx_empty_i      (rx_empty),
    .rx_full_i       (rx_full),
    .rx_byte_valid_i (rx_byte_valid),
    .rx_frame_err_i  (rx_frame_err)
  );

  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (tx_push),
    .wdata_i (tx_wdata),
    .pop_i   (tx_pop),
    .rdata_o (tx_head),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fifo_empty_i (tx_empty),
    .fifo_data_i  (tx_head),
    .fifo_pop_o   (tx_pop),
    .busy_o       (tx_busy),
    .tx_o         (tx_o)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_i         (rx_i),
    .byte_o       (rx_byte),
    .byte_valid_o (rx_byte_valid),
    .frame_err_o  (rx_frame_err)
  );

  // A byte that arrives while the FIFO is full is dropped here and flagged as overrun
  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rx_byte_valid),
    .wdata_i (rx_byte),
    .pop_i   (rx_pop),
    .rdata_o (rx_head),
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

endmodule

//--- test/tb_clk_gen.sv
// Free-running testbench clock and active-low reset
// Reset is released on a rising edge after RESET_CYCLES edges
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- test/tb_uart_top.sv
// Testbench for the AXI4-Lite UART, checks stop the run at the first mismatch
// rx_i comes either from tx_o (loopback) or from a bit-level frame driver
`timescale 1ns/1ps

module tb_uart_top;

  import uart_pkg::*;

  localparam int CLKS_PER_BIT   = 8;
  localparam int FIFO_DEPTH     = 4;
  localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
  // Room for 40 frame times plus AXI polling overhead
  localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES + 500;
  localparam logic [31:0] IDLE_STATUS = 32'h1 << STAT_TX_IDLE;

  logic        clk;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        tx_line;
  logic        drv_line;
  logic        loopback;
  logic [31:0] lcg_state = 32'd73;
  int          cycle_cnt = 0;
  logic [7:0]  sent [$];

  tb_clk_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(16)) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  uart_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bresp_o   (bresp),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rx_i      (loopback ? tx_line : drv_line),
    .tx_o      (tx_line)
  );

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("TIMEOUT: no end of test after %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
    end
  end

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s: expected 0x%08h actual 0x%08h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    do @(posedge clk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  // Polls STATUS until the given bit reads as one
  task automatic wait_status_bit(input int pos);
    logic [31:0] data;
    logic [1:0]  resp;
    do begin
      axil_read(REG_STATUS, data, resp);
    end while (!data[pos]);
  endtask

  task automatic drive_bit(input logic value);
    drv_line <= value;
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic stop_bit);
    @(posedge clk);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(stop_bit);
    drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  task automatic read_expect(input string name, input logic [3:0] addr,
                             input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    expect_equal({name, " resp"}, 32'(exp_resp), 32'(resp));
    expect_equal({name, " data"}, exp_data, data);
  endtask

  task automatic write_expect(input string name, input logic [3:0] addr,
                              input logic [31:0] data, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    expect_equal({name, " bresp"}, 32'(exp_resp), 32'(resp));
  endtask

  initial begin
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    drv_line = 1'b1;
    loopback = 1'b1;
    do @(posedge clk); while (!rst_n);

    // Reset state
    expect_equal("reset tx_o", 32'h1, 32'(tx_line));
    read_expect("reset status", REG_STATUS, IDLE_STATUS, RESP_OKAY);
    read_expect("reset rxdata", REG_RXDATA, 32'h0, RESP_SLVERR);
    read_expect("unmapped read", 4'hc, 32'h0, RESP_SLVERR);
    write_expect("unmapped write", 4'hc, 32'h0, RESP_SLVERR);

    // Loopback order, four bytes fit the receive FIFO
    for (int i = 0; i < 4; i++) begin
      sent.push_back(rand_byte());
      write_expect("loopback write", REG_TXDATA, {24'h0, sent[i]}, RESP_OKAY);
    end
    wait_status_bit(STAT_TX_IDLE);
    repeat (FRAME_CYCLES) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      read_expect($sformatf("loopback byte %0d", i), REG_RXDATA, {24'h0, sent[i]},
                  RESP_OKAY);
    end
    read_expect("loopback status", REG_STATUS, IDLE_STATUS, RESP_OKAY);

    // Transmit back-pressure, one byte in the serializer and FIFO_DEPTH queued
    sent.delete();
    for (int i = 0; i < 6; i++) begin
      sent.push_back(rand_byte());
      write_expect($sformatf("backpressure write %0d", i + 1), REG_TXDATA,
                   {24'h0, sent[i]}, (i < 5) ? RESP_OKAY : RESP_SLVERR);
    end
    for (int i = 0; i < 5; i++) begin
      wait_status_bit(STAT_RX_VALID);
      read_expect($sformatf("backpressure byte %0d", i), REG_RXDATA, {24'h0, sent[i]},
                  RESP_OKAY);
    end
    wait_status_bit(STAT_TX_IDLE);
    repeat (FRAME_CYCLES) @(posedge clk);
    read_expect("backpressure extra byte", REG_RXDATA, 32'h0, RESP_SLVERR);
    read_expect("backpressure status", REG_STATUS, IDLE_STATUS, RESP_OKAY);

    // Receive overrun, the fifth byte finds the receive FIFO full
    sent.delete();
    for (int i = 0; i < 5; i++) begin
      sent.push_back(rand_byte());
      write_expect("overrun write", REG_TXDATA, {24'h0, sent[i]}, RESP_OKAY);
    end
    wait_status_bit(STAT_TX_IDLE);
    repeat (FRAME_CYCLES) @(posedge clk);
    read_expect("overrun status", REG_STATUS,
                IDLE_STATUS | (32'h1 << STAT_RX_VALID) | (32'h1 << STAT_OVERRUN), RESP_OKAY);
    for (int i = 0; i < 4; i++) begin
      read_expect($sformatf("overrun byte %0d", i), REG_RXDATA, {24'h0, sent[i]},
                  RESP_OKAY);
    end
    write_expect("overrun clear", REG_STATUS, 32'h1 << STAT_OVERRUN, RESP_OKAY);
    read_expect("overrun cleared", REG_STATUS, IDLE_STATUS, RESP_OKAY);

    // Frame error from a zero stop bit on the driven line
    @(posedge clk);
    loopback <= 1'b0;
    send_frame(rand_byte(), 1'b0);
    read_expect("frame error status", REG_STATUS,
                IDLE_STATUS | (32'h1 << STAT_FRAME_ERR), RESP_OKAY);
    read_expect("frame error rxdata", REG_RXDATA, 32'h0, RESP_SLVERR);
    write_expect("frame error clear", REG_STATUS, 32'h1 << STAT_FRAME_ERR, RESP_OKAY);
    read_expect("frame error cleared", REG_STATUS, IDLE_STATUS, RESP_OKAY);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- flist.f
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_axil_regs.sv
rtl/uart_top.sv
test/tb_clk_gen.sv
test/tb_uart_top.sv

//--- Bender.yml
package:
  name: uart_axil

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_fifo.sv
  - rtl/uart_tx.sv
  - rtl/uart_rx.sv
  - rtl/uart_axil_regs.sv
  - rtl/uart_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_uart_top.sv
